// ==== rtl/id_defs.svh ====
`ifndef ID_DEFS_SVH
`define ID_DEFS_SVH

// datapath widths
`define WORD_W          32
`define HALF_W          16
`define REG_ADDR_W      5
`define ALUOP_W         8
`define ALUSEL_W        3

// instruction fields
`define OP_RANGE        31:26
`define RS_RANGE        25:21
`define RT_RANGE        20:16
`define RD_RANGE        15:11
`define SA_RANGE        10:6
`define FUNCT_RANGE     5:0
`define IMM_RANGE       15:0
`define SHIFT_PFX_RANGE 31:21   // all zero for sll/srl/sra

// primary opcodes
`define OP_SPECIAL      6'b000000
`define OP_ORI          6'b001101
`define OP_ANDI         6'b001100
`define OP_XORI         6'b001110
`define OP_LUI          6'b001111
`define OP_SLTI         6'b001010
`define OP_SLTIU        6'b001011
`define OP_ADDI         6'b001000
`define OP_ADDIU        6'b001001

// funct codes under the special opcode
`define FUNCT_AND       6'b100100
`define FUNCT_OR        6'b100101
`define FUNCT_XOR       6'b100110
`define FUNCT_NOR       6'b100111
`define FUNCT_SLL       6'b000000
`define FUNCT_SRL       6'b000010
`define FUNCT_SRA       6'b000011
`define FUNCT_SLLV      6'b000100
`define FUNCT_SRLV      6'b000110
`define FUNCT_SRAV      6'b000111
`define FUNCT_SLT       6'b101010
`define FUNCT_SLTU      6'b101011
`define FUNCT_ADD       6'b100000
`define FUNCT_ADDU      6'b100001
`define FUNCT_SUB       6'b100010
`define FUNCT_SUBU      6'b100011

// register 0, also the destination of a bubble
`define NOP_REG_ADDR    5'b00000

`endif

// ==== rtl/id_pkg.sv ====
`default_nettype none
`include "id_defs.svh"

package id_pkg;

    typedef logic [`WORD_W-1:0]     word_t;
    typedef logic [`REG_ADDR_W-1:0] reg_addr_t;

    // encodings as seen by the execute stage
    typedef enum logic [`ALUOP_W-1:0] {
        aluop_nop   = 8'b00000000,
        aluop_or    = 8'b00100101,
        aluop_and   = 8'b00100100,
        aluop_xor   = 8'b00100110,
        aluop_nor   = 8'b00100111,
        aluop_sll   = 8'b01111100,
        aluop_srl   = 8'b00000010,
        aluop_sra   = 8'b00000011,
        aluop_add   = 8'b00100000,
        aluop_addu  = 8'b00100001,
        aluop_addi  = 8'b01010101,
        aluop_addiu = 8'b01010110,
        aluop_sub   = 8'b00100010,
        aluop_subu  = 8'b00100011,
        aluop_slt   = 8'b00101010,
        aluop_sltu  = 8'b00101011
    } aluop_t;

    typedef enum logic [`ALUSEL_W-1:0] {
        sel_nop   = 3'b000,
        sel_logic = 3'b001,
        sel_shift = 3'b010,
        sel_arith = 3'b100
    } alusel_t;

    // register write seen in ex or mem
    typedef struct packed {
        logic      wreg;
        reg_addr_t wd;
        word_t     wdata;
    } fwd_t;

    typedef struct packed {
        aluop_t    aluop;
        alusel_t   alusel;
        reg_addr_t wd;
        logic      wreg;
        logic      reg1_read;
        logic      reg2_read;
        reg_addr_t reg1_addr;
        reg_addr_t reg2_addr;
        word_t     imm;
        logic      inst_valid;
    } decode_ctrl_t;

    typedef struct packed {
        aluop_t    aluop;
        alusel_t   alusel;
        word_t     reg1;
        word_t     reg2;
        reg_addr_t wd;
        logic      wreg;
    } ex_bundle_t;

    localparam ex_bundle_t ex_bubble = '0;   // nop, no write, wd = r0

endpackage

`default_nettype wire

// ==== rtl/inst_decoder.sv ====
`default_nettype none
`timescale 1ns/1ps
`include "id_defs.svh"

module inst_decoder
    import id_pkg::*;
(
    input  wire          clk,
    input  wire          reset_i,
    input  wire word_t   inst_i,
    output decode_ctrl_t ctrl_o
);

    word_t      inst_q;
    logic       live_q;     // low in the cycle after reset
    logic [5:0] op;
    logic [4:0] sa;
    logic [5:0] funct;
    logic       shift_imm;
    word_t      imm_zext;
    word_t      imm_sext;
    word_t      imm_upper;

    // result class follows from the operation
    function automatic alusel_t sel_of(aluop_t code);
        case (code)
            aluop_nop:                               return sel_nop;
            aluop_or, aluop_and, aluop_xor, aluop_nor: return sel_logic;
            aluop_sll, aluop_srl, aluop_sra:         return sel_shift;
            default:                                 return sel_arith;
        endcase
    endfunction

    always_ff @(posedge clk) begin
        if (reset_i) begin
            inst_q <= '0;
            live_q <= 1'b0;
        end else begin
            inst_q <= inst_i;
            live_q <= 1'b1;
        end
    end

    assign op    = inst_q[`OP_RANGE];
    assign sa    = inst_q[`SA_RANGE];
    assign funct = inst_q[`FUNCT_RANGE];

    assign imm_zext  = {{`HALF_W{1'b0}}, inst_q[`IMM_RANGE]};
    assign imm_sext  = {{`HALF_W{inst_q[15]}}, inst_q[`IMM_RANGE]};
    assign imm_upper = {inst_q[`IMM_RANGE], {`HALF_W{1'b0}}};

    // sll/srl/sra with rs = 0, wins over the special decode
    assign shift_imm = (inst_q[`SHIFT_PFX_RANGE] == 11'd0) &&
                       (funct == `FUNCT_SLL || funct == `FUNCT_SRL || funct == `FUNCT_SRA);

    always_comb begin
        ctrl_o = '0;
        ctrl_o.wd        = inst_q[`RD_RANGE];
        ctrl_o.reg1_addr = inst_q[`RS_RANGE];
        ctrl_o.reg2_addr = inst_q[`RT_RANGE];
        if (live_q) begin
            case (op)
                `OP_SPECIAL: begin
                    if (sa == 5'd0) begin
                        case (funct)
                            `FUNCT_OR:   ctrl_o.aluop = aluop_or;
                            `FUNCT_AND:  ctrl_o.aluop = aluop_and;
                            `FUNCT_XOR:  ctrl_o.aluop = aluop_xor;
                            `FUNCT_NOR:  ctrl_o.aluop = aluop_nor;
                            `FUNCT_SLLV: ctrl_o.aluop = aluop_sll;
                            `FUNCT_SRLV: ctrl_o.aluop = aluop_srl;
                            `FUNCT_SRAV: ctrl_o.aluop = aluop_sra;
                            `FUNCT_SLT:  ctrl_o.aluop = aluop_slt;
                            `FUNCT_SLTU: ctrl_o.aluop = aluop_sltu;
                            `FUNCT_ADD:  ctrl_o.aluop = aluop_add;
                            `FUNCT_ADDU: ctrl_o.aluop = aluop_addu;
                            `FUNCT_SUB:  ctrl_o.aluop = aluop_sub;
                            `FUNCT_SUBU: ctrl_o.aluop = aluop_subu;
                            default:     ctrl_o.aluop = aluop_nop;
                        endcase
                        // reg-reg forms read rs and rt
                        ctrl_o.reg1_read = (ctrl_o.aluop != aluop_nop);
                        ctrl_o.reg2_read = (ctrl_o.aluop != aluop_nop);
                    end
                end
                `OP_ORI:   ctrl_o.aluop = aluop_or;
                `OP_ANDI:  ctrl_o.aluop = aluop_and;
                `OP_XORI:  ctrl_o.aluop = aluop_xor;
                `OP_LUI:   ctrl_o.aluop = aluop_or;
                `OP_SLTI:  ctrl_o.aluop = aluop_slt;
                `OP_SLTIU: ctrl_o.aluop = aluop_sltu;
                `OP_ADDI:  ctrl_o.aluop = aluop_addi;
                `OP_ADDIU: ctrl_o.aluop = aluop_addiu;
                default:   ctrl_o.aluop = aluop_nop;
            endcase

            if (op != `OP_SPECIAL && ctrl_o.aluop != aluop_nop) begin
                ctrl_o.wd        = inst_q[`RT_RANGE];
                ctrl_o.reg1_read = 1'b1;    // lui reads rs as well
                if (op == `OP_LUI) begin
                    ctrl_o.imm = imm_upper;
                end else if (sel_of(ctrl_o.aluop) == sel_logic) begin
                    ctrl_o.imm = imm_zext;
                end else begin
                    ctrl_o.imm = imm_sext;
                end
            end

            if (shift_imm) begin
                case (funct)
                    `FUNCT_SRL: ctrl_o.aluop = aluop_srl;
                    `FUNCT_SRA: ctrl_o.aluop = aluop_sra;
                    default:    ctrl_o.aluop = aluop_sll;
                endcase
                ctrl_o.reg1_read = 1'b0;    // operand 1 is the shift amount
                ctrl_o.reg2_read = 1'b1;
                ctrl_o.imm[4:0]  = sa;
            end

            ctrl_o.alusel     = sel_of(ctrl_o.aluop);
            ctrl_o.wreg       = (ctrl_o.aluop != aluop_nop);
            ctrl_o.inst_valid = ctrl_o.wreg;
        end
    end

    // every kept instruction writes from at least one register source
    a_wreg_reads: assert property (@(posedge clk) disable iff (reset_i)
        ctrl_o.wreg |-> (ctrl_o.reg1_read || ctrl_o.reg2_read));

endmodule

`default_nettype wire

// ==== rtl/operand_select.sv ====
`default_nettype none
`timescale 1ns/1ps
`include "id_defs.svh"

module operand_select
    import id_pkg::*;
(
    input  wire            read_i,
    input  wire reg_addr_t addr_i,
    input  wire word_t     imm_i,
    input  wire word_t     reg_data_i,
    input  wire fwd_t      ex_fwd_i,
    input  wire fwd_t      mem_fwd_i,
    output word_t          operand_o
);

    logic ex_hit;
    logic mem_hit;

    // r0 is not special here, a write to it forwards too
    assign ex_hit  = ex_fwd_i.wreg && (ex_fwd_i.wd == addr_i);
    assign mem_hit = mem_fwd_i.wreg && (mem_fwd_i.wd == addr_i);

    always_comb begin
        if (!read_i) begin
            operand_o = imm_i;
        end else if (ex_hit) begin
            operand_o = ex_fwd_i.wdata;     // youngest write first
        end else if (mem_hit) begin
            operand_o = mem_fwd_i.wdata;
        end else begin
            operand_o = reg_data_i;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/id_ex_reg.sv ====
`default_nettype none
`timescale 1ns/1ps
`include "id_defs.svh"

module id_ex_reg
    import id_pkg::*;
(
    input  wire               clk,
    input  wire               reset_i,
    input  wire decode_ctrl_t ctrl_i,
    input  wire word_t        reg1_i,
    input  wire word_t        reg2_i,
    output ex_bundle_t        ex_o
);

    ex_bundle_t ex_d;

    always_comb begin
        ex_d.aluop  = ctrl_i.aluop;
        ex_d.alusel = ctrl_i.alusel;
        ex_d.reg1   = reg1_i;
        ex_d.reg2   = reg2_i;
        ex_d.wd     = ctrl_i.wd;
        ex_d.wreg   = ctrl_i.wreg;
        if (!ctrl_i.inst_valid) begin
            ex_d = ex_bubble;   // unknown opcode goes down as a nop
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            ex_o <= ex_bubble;
        end else begin
            ex_o <= ex_d;
        end
    end

    // a nop class never reaches writeback with a write
    a_nop_no_write: assert property (@(posedge clk) disable iff (reset_i)
        (ex_o.alusel == sel_nop) |-> !ex_o.wreg);

    a_reset_bubble: assert property (@(posedge clk)
        reset_i |=> (ex_o == ex_bubble));

endmodule

`default_nettype wire

// ==== rtl/id_stage.sv ====
`default_nettype none
`timescale 1ns/1ps
`include "id_defs.svh"

module id_stage
    import id_pkg::*;
(
    input  wire        clk,
    input  wire        reset_i,
    input  wire word_t inst_i,

    // register file read port, data returns in the same cycle
    output reg_addr_t  reg1_addr_o,
    output reg_addr_t  reg2_addr_o,
    output logic       reg1_read_o,
    output logic       reg2_read_o,
    input  wire word_t reg1_data_i,
    input  wire word_t reg2_data_i,

    input  wire fwd_t  ex_fwd_i,
    input  wire fwd_t  mem_fwd_i,

    output ex_bundle_t ex_o
);

    decode_ctrl_t ctrl;
    word_t        reg1;
    word_t        reg2;

    inst_decoder u_decoder (
        .clk     (clk),
        .reset_i (reset_i),
        .inst_i  (inst_i),
        .ctrl_o  (ctrl)
    );

    assign reg1_addr_o = ctrl.reg1_addr;
    assign reg2_addr_o = ctrl.reg2_addr;
    assign reg1_read_o = ctrl.reg1_read;
    assign reg2_read_o = ctrl.reg2_read;

    operand_select u_op1 (
        .read_i     (ctrl.reg1_read),
        .addr_i     (ctrl.reg1_addr),
        .imm_i      (ctrl.imm),
        .reg_data_i (reg1_data_i),
        .ex_fwd_i   (ex_fwd_i),
        .mem_fwd_i  (mem_fwd_i),
        .operand_o  (reg1)
    );

    operand_select u_op2 (
        .read_i     (ctrl.reg2_read),
        .addr_i     (ctrl.reg2_addr),
        .imm_i      (ctrl.imm),
        .reg_data_i (reg2_data_i),
        .ex_fwd_i   (ex_fwd_i),
        .mem_fwd_i  (mem_fwd_i),
        .operand_o  (reg2)
    );

    id_ex_reg u_ex_reg (
        .clk     (clk),
        .reset_i (reset_i),
        .ctrl_i  (ctrl),
        .reg1_i  (reg1),
        .reg2_i  (reg2),
        .ex_o    (ex_o)
    );

endmodule

`default_nettype wire

// ==== dv/id_model.svh ====
`ifndef ID_MODEL_SVH
`define ID_MODEL_SVH

logic [31:0] lcg_state = 32'h7036ee69;

// two lcg steps, upper halves only since the low bits repeat quickly
function automatic logic [31:0] next_rand();
    logic [15:0] hi;
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    hi = lcg_state[31:16];
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return {hi, lcg_state[31:16]};
endfunction

function automatic alusel_t class_of(aluop_t op);
    case (op)
        aluop_nop:                                 return sel_nop;
        aluop_or, aluop_and, aluop_xor, aluop_nor: return sel_logic;
        aluop_sll, aluop_srl, aluop_sra:           return sel_shift;
        default:                                   return sel_arith;
    endcase
endfunction

// expected decode of one instruction word
function automatic decode_ctrl_t model_decode(word_t inst);
    decode_ctrl_t d;
    logic [5:0]   fn;
    logic         shift_form;
    logic         imm_form;
    fn = inst[5:0];
    shift_form = (inst[31:21] == 11'd0) && (fn inside {`FUNCT_SLL, `FUNCT_SRL, `FUNCT_SRA});
    imm_form = 1'b0;
    d = '0;
    d.reg1_addr = inst[25:21];
    d.reg2_addr = inst[20:16];
    if (shift_form) begin
        d.aluop = (fn == `FUNCT_SLL) ? aluop_sll : (fn == `FUNCT_SRL) ? aluop_srl : aluop_sra;
        d.imm = {27'd0, inst[10:6]};   // shift amount
    end else if (inst[31:26] == `OP_SPECIAL && inst[10:6] == 5'd0) begin
        case (fn)
            `FUNCT_OR:   d.aluop = aluop_or;
            `FUNCT_AND:  d.aluop = aluop_and;
            `FUNCT_XOR:  d.aluop = aluop_xor;
            `FUNCT_NOR:  d.aluop = aluop_nor;
            `FUNCT_SLLV: d.aluop = aluop_sll;
            `FUNCT_SRLV: d.aluop = aluop_srl;
            `FUNCT_SRAV: d.aluop = aluop_sra;
            `FUNCT_ADD:  d.aluop = aluop_add;
            `FUNCT_ADDU: d.aluop = aluop_addu;
            `FUNCT_SUB:  d.aluop = aluop_sub;
            `FUNCT_SUBU: d.aluop = aluop_subu;
            `FUNCT_SLT:  d.aluop = aluop_slt;
            `FUNCT_SLTU: d.aluop = aluop_sltu;
            default:     d.aluop = aluop_nop;
        endcase
    end else begin
        imm_form = 1'b1;
        case (inst[31:26])
            `OP_ORI, `OP_LUI: d.aluop = aluop_or;
            `OP_ANDI:         d.aluop = aluop_and;
            `OP_XORI:         d.aluop = aluop_xor;
            `OP_SLTI:         d.aluop = aluop_slt;
            `OP_SLTIU:        d.aluop = aluop_sltu;
            `OP_ADDI:         d.aluop = aluop_addi;
            `OP_ADDIU:        d.aluop = aluop_addiu;
            default:          d.aluop = aluop_nop;
        endcase
        if (inst[31:26] == `OP_LUI)
            d.imm = {inst[15:0], 16'd0};
        else if (class_of(d.aluop) == sel_logic)
            d.imm = {16'd0, inst[15:0]};
        else
            d.imm = {{16{inst[15]}}, inst[15:0]};
    end
    d.inst_valid = (d.aluop != aluop_nop);
    d.wreg       = d.inst_valid;
    d.alusel     = class_of(d.aluop);
    d.wd         = imm_form ? inst[20:16] : inst[15:11];
    d.reg1_read  = d.inst_valid && !shift_form;
    d.reg2_read  = d.inst_valid && !imm_form;
    return d;
endfunction

function automatic word_t fwd_operand(logic rd_en, reg_addr_t addr, word_t imm, word_t rf,
                                      fwd_t ex, fwd_t mem);
    if (!rd_en)
        return imm;
    if (ex.wreg && ex.wd == addr)
        return ex.wdata;   // ex holds the younger write
    if (mem.wreg && mem.wd == addr)
        return mem.wdata;
    return rf;
endfunction

function automatic ex_bundle_t expected_bundle(decode_ctrl_t d, word_t rf1, word_t rf2,
                                               fwd_t ex, fwd_t mem);
    ex_bundle_t b;
    b = '0;   // bubble unless the word decodes
    if (d.inst_valid) begin
        b.aluop  = d.aluop;
        b.alusel = d.alusel;
        b.reg1   = fwd_operand(d.reg1_read, d.reg1_addr, d.imm, rf1, ex, mem);
        b.reg2   = fwd_operand(d.reg2_read, d.reg2_addr, d.imm, rf2, ex, mem);
        b.wd     = d.wd;
        b.wreg   = d.wreg;
    end
    return b;
endfunction

`endif

// ==== dv/id_stage_tb.sv ====
`default_nettype none
`timescale 1ns/1ps
`include "id_defs.svh"

module id_stage_tb
    import id_pkg::*;
();

    localparam int num_cycles = 2000;

    logic         clk;
    logic         rst;
    word_t        inst;
    reg_addr_t    reg1_addr;
    reg_addr_t    reg2_addr;
    logic         reg1_read;
    logic         reg2_read;
    word_t        reg1_data;
    word_t        reg2_data;
    fwd_t         ex_fwd;
    fwd_t         mem_fwd;
    ex_bundle_t   ex_out;

    word_t        regfile [32];
    ex_bundle_t   exp_q [$];
    decode_ctrl_t exp_dec;
    word_t        held_inst;
    logic [31:0]  rf_pick;
    int           bundle_errors;
    int           read_errors;
    int           cyc;

    `include "id_model.svh"

    // last three are the immediate shifts
    localparam logic [5:0] special_functs [16] = '{
        `FUNCT_OR, `FUNCT_AND, `FUNCT_XOR, `FUNCT_NOR, `FUNCT_SLLV, `FUNCT_SRLV,
        `FUNCT_SRAV, `FUNCT_ADD, `FUNCT_ADDU, `FUNCT_SUB, `FUNCT_SUBU, `FUNCT_SLT,
        `FUNCT_SLTU, `FUNCT_SLL, `FUNCT_SRL, `FUNCT_SRA};
    localparam logic [5:0] imm_ops [8] = '{
        `OP_ORI, `OP_ANDI, `OP_XORI, `OP_LUI, `OP_SLTI, `OP_SLTIU, `OP_ADDI, `OP_ADDIU};
    // mult, multu, mfhi, mflo, mthi, mtlo, movn, movz
    localparam logic [5:0] dropped_functs [8] = '{
        6'b011000, 6'b011001, 6'b010000, 6'b010010, 6'b010001, 6'b010011, 6'b001011, 6'b001010};

    id_stage UUT (
        .clk         (clk),
        .reset_i     (rst),
        .inst_i      (inst),
        .reg1_addr_o (reg1_addr),
        .reg2_addr_o (reg2_addr),
        .reg1_read_o (reg1_read),
        .reg2_read_o (reg2_read),
        .reg1_data_i (reg1_data),
        .reg2_data_i (reg2_data),
        .ex_fwd_i    (ex_fwd),
        .mem_fwd_i   (mem_fwd),
        .ex_o        (ex_out)
    );

    assign reg1_data = regfile[reg1_addr];
    assign reg2_data = regfile[reg2_addr];

    function automatic word_t random_inst();
        logic [31:0] r;
        logic [31:0] f;
        r = next_rand();
        f = next_rand();
        if (f[31:28] < 4'd11) begin
            if (f[27])
                return {imm_ops[f[2:0]], r[25:0]};
            if (f[6:3] >= 4'd13)
                return {11'd0, r[20:6], special_functs[f[6:3]]};
            return {6'd0, r[25:11], 5'd0, special_functs[f[6:3]]};
        end else if (f[31:28] < 4'd14) begin
            if (f[26])
                return {6'd0, r[25:6], dropped_functs[f[2:0]]};
            return {f[25] ? 6'b011100 : 6'b110011, r[25:0]};   // special2 group or pref
        end
        return r;
    endfunction

    // about a third aim at a source of the word in decode
    function automatic fwd_t random_fwd(word_t src);
        fwd_t        w;
        logic [31:0] r;
        r = next_rand();
        w.wreg  = r[31] | r[30];
        w.wd    = (r[29:22] < 8'd85) ? (r[21] ? src[`RS_RANGE] : src[`RT_RANGE]) : r[4:0];
        w.wdata = next_rand();
        return w;
    endfunction

    task automatic check_bundle(ex_bundle_t exp, string what);
        if (ex_out !== exp) begin
            bundle_errors++;
            $write("MISMATCH at %0t: %s got/exp aluop %h/%h alusel %h/%h", $time, what,
                   ex_out.aluop, exp.aluop, ex_out.alusel, exp.alusel);
            $display(" reg1 %h/%h reg2 %h/%h wd %0d/%0d wreg %b/%b", ex_out.reg1, exp.reg1,
                     ex_out.reg2, exp.reg2, ex_out.wd, exp.wd, ex_out.wreg, exp.wreg);
        end
    endtask

    task automatic check_reads(decode_ctrl_t exp, string what);
        if (reg1_read !== exp.reg1_read || reg2_read !== exp.reg2_read ||
            reg1_addr !== exp.reg1_addr || reg2_addr !== exp.reg2_addr) begin
            read_errors++;
            $display("MISMATCH at %0t: %s read enables %b%b/%b%b addresses %0d,%0d/%0d,%0d",
                     $time, what, reg1_read, reg2_read, exp.reg1_read, exp.reg2_read,
                     reg1_addr, reg2_addr, exp.reg1_addr, exp.reg2_addr);
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    initial begin
        #((num_cycles + 10) * 40);
        $display("watchdog expired before the test sequence completed");
        $display("*** TEST FAILED ***");
        $finish;
    end

    initial begin
        rst = 1'b1;
        inst = '0;
        ex_fwd = '0;
        mem_fwd = '0;
        bundle_errors = 0;
        read_errors = 0;
        for (int i = 0; i < 32; i++)
            regfile[i[4:0]] = next_rand();
        repeat (2) @(posedge clk);
        #2;
        rst = 1'b0;
        check_bundle('0, "reset");
        check_reads('0, "reset");
        inst = random_inst();
        for (cyc = 0; cyc < num_cycles; cyc++) begin
            @(posedge clk);
            held_inst = inst;   // now in the decoder register
            #2;
            if (exp_q.size() > 0)
                check_bundle(exp_q.pop_front(), "pipeline");
            exp_dec = model_decode(held_inst);
            check_reads(exp_dec, "decode");
            rf_pick = next_rand();
            regfile[rf_pick[31:27]] = next_rand();
            inst = random_inst();
            ex_fwd = random_fwd(held_inst);
            mem_fwd = random_fwd(held_inst);
            #36;
            exp_q.push_back(expected_bundle(exp_dec, regfile[exp_dec.reg1_addr],
                                            regfile[exp_dec.reg2_addr], ex_fwd, mem_fwd));
        end
        @(posedge clk);
        #2;
        check_bundle(exp_q.pop_front(), "pipeline");
        $display("errors: bundle %0d, read request %0d", bundle_errors, read_errors);
        if (bundle_errors + read_errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== project.f ====
+incdir+rtl
+incdir+dv
rtl/id_pkg.sv
rtl/inst_decoder.sv
rtl/operand_select.sv
rtl/id_ex_reg.sv
rtl/id_stage.sv
dv/id_stage_tb.sv

// ==== Makefile ====
VERILATOR  := verilator
TOP        := id_stage_tb
RTL_TOP    := id_stage
FILELIST   := project.f
OBJ_DIR    := obj_dir
COMMON     := --timing --assert --timescale 1ns/1ps
LINT_FLAGS := --lint-only $(COMMON)
SIM_FLAGS  := --binary $(COMMON) --Mdir $(OBJ_DIR)
PASS_MSG   := *** TEST PASSED ***

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TOP)
	out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qF '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)
